// ==== Makefile ====
TOP := mcu_io_tb
SIM := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): mcu_io.f $(shell cat mcu_io.f)
	verilator --binary --timing --assert -f mcu_io.f --top-module $(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

lint:
	verilator --lint-only --timing --assert -f mcu_io.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== logic/io_regs.sv ====
// I/O register block
// Decodes I/O strobes, drives UART transmit and read strobes,
// registers the read data for the cycle after io_rd

`timescale 1ns/1ps
`default_nettype none

module io_regs import mcu_pkg::*, uart_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  cpu_bus_t            bus_i,
  input  uart_stat_t          stat_i,
  input  byte_t               rx_byte_i,   // Held UART byte
  input  logic [CYC_BITS-1:0] cycle_i,
  output logic                u_wr_o,      // Transmit pulse
  output byte_t               u_byte_o,    // Transmit byte
  output logic                u_rd_o,      // Receive taken pulse
  output logic [WIDTH-1:0]    io_dout_o
);

  io_reg_e          reg_sel;
  logic             sel_udata;
  logic [WIDTH-1:0] rd_data;

  assign reg_sel   = io_reg_e'(bus_i.addr[2:0]);
  assign sel_udata = (reg_sel == IO_UDATA);

  // Write while busy is dropped
  assign u_wr_o   = bus_i.io_wr && sel_udata && stat_i.ready;
  assign u_byte_o = bus_i.dout[7:0];
  assign u_rd_o   = bus_i.io_rd && sel_udata;

  always_comb begin
    case (reg_sel)
      IO_UDATA: rd_data = WIDTH'(rx_byte_i);
      IO_USTAT: rd_data = WIDTH'({stat_i.full, stat_i.ready});
      IO_CYCLE: rd_data = WIDTH'(cycle_i);
      default:  rd_data = '0;              // Unmapped registers
    endcase
  end

  // Holds until the next read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      io_dout_o <= '0;
    end else if (bus_i.io_rd) begin
      io_dout_o <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== logic/irq_ctrl.sv ====
// Interrupt controller
// Free-running cycle counter, edge detect of UART status,
// pending register with acknowledge and priority encoder

`timescale 1ns/1ps
`default_nettype none

module irq_ctrl import mcu_pkg::*, uart_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_stat_t          stat_i,     // UART ready and full levels
  input  logic                iack_i,     // Clears the bit on ivec_o
  output logic [CYC_BITS-1:0] cycle_o,
  output logic                irq_o,
  output logic [3:0]          ivec_o
);

  logic [CYC_BITS-1:0]      cyc_q;
  logic                     ready_q;      // Previous levels for edge detect
  logic                     full_q;
  logic                     wrap;
  logic [IRQ_URX:IRQ_CYCLE] pend_q;       // No bit for IRQ_NONE
  logic [IRQ_URX:IRQ_CYCLE] pend_d;
  irq_src_e                 ivec;

  assign wrap = (cyc_q == '1);            // Next count is zero

  always_comb begin
    pend_d = pend_q;
    if (iack_i && ivec != IRQ_NONE) pend_d[ivec] = 1'b0;
    // Sources set after the clear, so a same-cycle event survives
    if (wrap) pend_d[IRQ_CYCLE] = 1'b1;
    if (stat_i.ready && !ready_q) pend_d[IRQ_UTX] = 1'b1;
    if (stat_i.full && !full_q) pend_d[IRQ_URX] = 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_q   <= '0;
      ready_q <= 1'b1;                    // Ready out of reset is no edge
      full_q  <= 1'b0;
      pend_q  <= '0;
    end else begin
      cyc_q   <= cyc_q + 1'b1;
      ready_q <= stat_i.ready;
      full_q  <= stat_i.full;
      pend_q  <= pend_d;
    end
  end

  // Priority encoder, highest bit last
  always_comb begin
    ivec = IRQ_NONE;
    if (pend_q[IRQ_CYCLE]) ivec = IRQ_CYCLE;
    if (pend_q[IRQ_UTX]) ivec = IRQ_UTX;
    if (pend_q[IRQ_URX]) ivec = IRQ_URX;
  end

  assign ivec_o  = ivec;
  assign irq_o   = (ivec != IRQ_NONE);
  assign cycle_o = cyc_q;

endmodule

`default_nettype wire

// ==== logic/mcu_io.sv ====
// MCU peripheral side
// Data RAM, I/O registers, UART and interrupt controller
// behind the CPU's strobe bus

`timescale 1ns/1ps
`default_nettype none

module mcu_io import mcu_pkg::*, uart_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  cpu_bus_t         bus_i,
  output logic [WIDTH-1:0] mem_dout_o,   // Valid the cycle after mem_rd
  output logic [WIDTH-1:0] io_dout_o,    // Valid the cycle after io_rd
  output logic             irq_o,
  output logic [3:0]       ivec_o,
  input  logic             iack_i,
  input  logic             rxd_i,
  output logic             txd_o
);

  logic                u_wr;
  logic                u_rd;
  byte_t               u_byte;           // To transmitter
  byte_t               rx_byte;          // From receiver
  uart_stat_t          u_stat;
  logic [CYC_BITS-1:0] cycle;

  spram i_ram (
    .clk    (clk),
    .rst_n  (rst_n),
    .addr_i (bus_i.addr[DATA_SIZE-1:0]),
    .din_i  (bus_i.dout),
    .we_i   (bus_i.mem_wr),
    .re_i   (bus_i.mem_rd),
    .dout_o (mem_dout_o)
  );

  io_regs i_io (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus_i     (bus_i),
    .stat_i    (u_stat),
    .rx_byte_i (rx_byte),
    .cycle_i   (cycle),
    .u_wr_o    (u_wr),
    .u_byte_o  (u_byte),
    .u_rd_o    (u_rd),
    .io_dout_o (io_dout_o)
  );

  uart i_uart (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_i   (u_wr),
    .din_i  (u_byte),
    .rd_i   (u_rd),
    .rxd_i  (rxd_i),
    .txd_o  (txd_o),
    .stat_o (u_stat),
    .dout_o (rx_byte)
  );

  irq_ctrl i_irq (
    .clk     (clk),
    .rst_n   (rst_n),
    .stat_i  (u_stat),
    .iack_i  (iack_i),
    .cycle_o (cycle),
    .irq_o   (irq_o),
    .ivec_o  (ivec_o)
  );

endmodule

`default_nettype wire

// ==== logic/mcu_pkg.sv ====
// MCU I/O package
// Processor bus, data memory size, I/O register map and interrupt numbers

`default_nettype none

package mcu_pkg;

  localparam int WIDTH     = 18;          // Data cell width
  localparam int DATA_SIZE = 8;           // log2 of data RAM depth
  localparam int CYC_BITS  = 8;           // Cycle counter, wraps every 256

  typedef logic [7:0] byte_t;             // UART payload byte

  // Strobes are one cycle wide, never two at once
  typedef struct packed {
    logic             io_rd;              // I/O read strobe
    logic             io_wr;              // I/O write strobe
    logic             mem_rd;             // Data memory read enable
    logic             mem_wr;             // Data memory write enable
    logic [14:0]      addr;               // Memory and I/O address
    logic [WIDTH-1:0] dout;               // Write data from CPU
  } cpu_bus_t;

  // I/O registers, addr[2:0]
  typedef enum logic [2:0] {
    IO_UDATA = 3'd0,                      // UART data
    IO_USTAT = 3'd1,                      // UART status {full, ready}
    IO_CYCLE = 3'd2                       // Cycle counter
  } io_reg_e;

  // Highest number wins
  typedef enum logic [3:0] {
    IRQ_NONE  = 4'd0,
    IRQ_CYCLE = 4'd1,                     // Counter wrap
    IRQ_UTX   = 4'd2,                     // Transmitter ready
    IRQ_URX   = 4'd3                      // Byte received
  } irq_src_e;

endpackage

`default_nettype wire

// ==== logic/spram.sv ====
// Single-port data RAM
// Synchronous write, read data registered on the read enable

`timescale 1ns/1ps
`default_nettype none

module spram import mcu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [DATA_SIZE-1:0] addr_i,      // Cell address
  input  logic [WIDTH-1:0]     din_i,       // Write data
  input  logic                 we_i,        // Write enable
  input  logic                 re_i,        // Read enable
  output logic [WIDTH-1:0]     dout_o       // Read data, held until next read
);

  logic [WIDTH-1:0] mem [2**DATA_SIZE];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[addr_i] <= din_i;
    end
  end

  // Read register, holds between reads
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dout_o <= '0;
    end else if (re_i) begin
      dout_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== logic/uart.sv ====
// Byte UART
// 8N1 transmitter and receiver, BIT_PERIOD clocks per bit
// Receive input runs through a two-flop synchronizer

`timescale 1ns/1ps
`default_nettype none

module uart import mcu_pkg::*, uart_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wr_i,          // Transmit strobe, taken only when ready
  input  byte_t      din_i,         // Byte to send
  input  logic       rd_i,          // Received byte taken, clears full
  input  logic       rxd_i,         // Async serial input
  output logic       txd_o,         // Serial output, idles high
  output uart_stat_t stat_o,
  output byte_t      dout_o         // Last received byte
);

  tx_state_e            tx_state;
  logic [BIT_CNT_W-1:0] tx_cnt;     // Bit timer
  logic [2:0]           tx_bit;     // Data bit index
  byte_t                tx_sh;      // Shift register, LSB goes out next
  logic                 tx_end;

  rx_state_e            rx_state;
  logic                 rx_s1;      // Synchronizer stages
  logic                 rx_s2;
  logic [BIT_CNT_W-1:0] rx_cnt;
  logic [2:0]           rx_bit;
  byte_t                rx_sh;      // Assembles LSB first
  byte_t                rx_q;       // Held byte
  logic                 full_q;
  logic                 rx_end;
  logic                 rx_mid;
  logic                 rx_done;    // Mid stop bit with a valid stop level

  assign tx_end  = (tx_cnt == BIT_CNT_W'(BIT_PERIOD - 1));
  assign rx_end  = (rx_cnt == BIT_CNT_W'(BIT_PERIOD - 1));
  assign rx_mid  = (rx_cnt == BIT_CNT_W'(BIT_HALF - 1));
  assign rx_done = (rx_state == RX_STOP) && rx_end && rx_s2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_state <= TX_IDLE;
      tx_cnt   <= '0;
      tx_bit   <= '0;
      txd_o    <= 1'b1;
    end else begin
      tx_cnt <= (tx_state == TX_IDLE || tx_end) ? '0 : tx_cnt + 1'b1;
      case (tx_state)
        TX_IDLE: if (wr_i) begin
          tx_state <= TX_START;
          txd_o    <= 1'b0;                      // Start bit
        end
        TX_START: if (tx_end) begin
          tx_state <= TX_DATA;
          txd_o    <= tx_sh[0];
        end
        TX_DATA: if (tx_end) begin
          tx_bit <= tx_bit + 1'b1;               // Wraps back to 0 after bit 7
          if (tx_bit == 3'd7) begin
            tx_state <= TX_STOP;
            txd_o    <= 1'b1;                    // Stop bit
          end else begin
            txd_o <= tx_sh[1];                   // Next bit, before the shift
          end
        end
        TX_STOP: if (tx_end) tx_state <= TX_IDLE;
        default: tx_state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (tx_state == TX_IDLE && wr_i) begin
      tx_sh <= din_i;
    end else if (tx_state == TX_DATA && tx_end) begin
      tx_sh <= tx_sh >> 1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1    <= 1'b1;
      rx_s2    <= 1'b1;
      rx_state <= RX_IDLE;
      rx_cnt   <= '0;
      rx_bit   <= '0;
      full_q   <= 1'b0;
    end else begin
      rx_s1  <= rxd_i;
      rx_s2  <= rx_s1;
      rx_cnt <= (rx_state == RX_IDLE || rx_end) ? '0 : rx_cnt + 1'b1;
      case (rx_state)
        RX_IDLE: if (!rx_s2) rx_state <= RX_START;    // Falling edge of start
        RX_START: if (rx_mid) begin
          rx_cnt   <= '0;                              // Realign to mid-bit
          rx_state <= rx_s2 ? RX_IDLE : RX_DATA;       // Glitch goes back to idle
        end
        RX_DATA: if (rx_end) begin
          rx_bit <= rx_bit + 1'b1;
          if (rx_bit == 3'd7) rx_state <= RX_STOP;
        end
        RX_STOP: if (rx_end) rx_state <= RX_IDLE;
        default: rx_state <= RX_IDLE;
      endcase
      if (rx_done) begin
        full_q <= 1'b1;                                // New byte wins over rd_i
      end else if (rd_i) begin
        full_q <= 1'b0;
      end
    end
  end

  // Framing error drops the byte
  always_ff @(posedge clk) begin
    if (rx_state == RX_DATA && rx_end) rx_sh <= {rx_s2, rx_sh[7:1]};
    if (rx_done) rx_q <= rx_sh;                        // Overwrites an unread byte
  end

  assign stat_o.ready = (tx_state == TX_IDLE);
  assign stat_o.full  = full_q;
  assign dout_o       = rx_q;

endmodule

`default_nettype wire

// ==== logic/uart_pkg.sv ====
// UART package
// Bit timing, transmit and receive states, status word

`default_nettype none

package uart_pkg;

  localparam int BIT_PERIOD = 8;                    // Clocks per bit
  localparam int BIT_HALF   = BIT_PERIOD / 2;       // Mid-bit sample point
  localparam int BIT_CNT_W  = $clog2(BIT_PERIOD);   // Bit timer width

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  typedef struct packed {
    logic full;                           // Received byte waiting
    logic ready;                          // Transmitter can take a byte
  } uart_stat_t;

endpackage

`default_nettype wire

// ==== mcu_io.f ====
logic/mcu_pkg.sv
logic/uart_pkg.sv
logic/spram.sv
logic/uart.sv
logic/irq_ctrl.sv
logic/io_regs.sv
logic/mcu_io.sv
test/tb_clk.sv
test/mcu_io_assert.sv
test/mcu_io_tb.sv

// ==== test/mcu_io_assert.sv ====
// Bus and interrupt assertions for the MCU peripheral top
// Bound into mcu_io, sees the UART status from inside

`timescale 1ns/1ps
`default_nettype none

module mcu_io_assert import mcu_pkg::*, uart_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input cpu_bus_t   bus_i,
  input logic       irq_o,
  input logic [3:0] ivec_o,
  input logic       iack_i,
  input logic       txd_o,
  input uart_stat_t stat_i
);

  // One strobe per cycle at most
  a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({bus_i.io_rd, bus_i.io_wr, bus_i.mem_rd, bus_i.mem_wr}))
    else $error("more than one bus strobe high");

  // Vector only drops on an acknowledge, irq_o follows it
  a_irq_vec: assert property (@(posedge clk) disable iff (!rst_n)
    !iack_i |=> (ivec_o >= $past(ivec_o)) && (irq_o == (ivec_o != 4'd0)))
    else $error("ivec_o dropped without iack_i or irq_o does not match");

  // Line idles high while the transmitter is free
  a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n)
    stat_i.ready |-> txd_o)
    else $error("txd_o low while transmitter ready");

endmodule

bind mcu_io mcu_io_assert i_assert (
  .clk    (clk),
  .rst_n  (rst_n),
  .bus_i  (bus_i),
  .irq_o  (irq_o),
  .ivec_o (ivec_o),
  .iack_i (iack_i),
  .txd_o  (txd_o),
  .stat_i (u_stat)
);

`default_nettype wire

// ==== test/mcu_io_tb.sv ====
// Testbench for the MCU peripheral side
// Plays the CPU on the strobe bus, UART looped back on itself

`timescale 1ns/1ps
`default_nettype none

module mcu_io_tb import mcu_pkg::*, uart_pkg::*;;

  localparam int MAX_CYCLES = 6000;               // About 3x the total test length
  localparam int RAM_N      = 64;
  localparam int GAP        = 37;                 // Idle cycles between counter reads

  logic             clk;
  logic             rst_n;
  cpu_bus_t         bus;
  logic [WIDTH-1:0] mem_dout;
  logic [WIDTH-1:0] io_dout;
  logic             irq;
  logic [3:0]       ivec;
  logic             iack;
  logic             txd;

  logic [WIDTH-1:0]     shadow [2**DATA_SIZE];    // Reference RAM
  logic [DATA_SIZE-1:0] addrs [RAM_N];
  logic [31:0]          rng;
  int                   errors;
  int                   checks;
  int                   cycles;
  logic [3:1]           pend_m;                   // Model pending set

  tb_clk i_clk (.clk_o(clk), .rst_n_o(rst_n));

  mcu_io i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus_i      (bus),
    .mem_dout_o (mem_dout),
    .io_dout_o  (io_dout),
    .irq_o      (irq),
    .ivec_o     (ivec),
    .iack_i     (iack),
    .rxd_i      (txd),                            // Loopback
    .txd_o      (txd)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Status word as the register map defines it
  function automatic uart_stat_t exp_stat(input logic full, input logic ready);
    uart_stat_t s;
    s.full  = full;
    s.ready = ready;
    return s;
  endfunction

  // Highest pending index wins
  function automatic logic [3:0] exp_vec(input logic [3:1] pend);
    logic [3:0] v;
    v = 4'd0;
    for (int i = 1; i <= 3; i++) begin
      if (pend[i]) v = 4'(i);
    end
    return v;
  endfunction

  task automatic check_word(input logic [WIDTH-1:0] got, input logic [WIDTH-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_stat(input uart_stat_t got, input uart_stat_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s full/ready %b%b, expected %b%b", $time, what,
               got.full, got.ready, exp.full, exp.ready);
    end
  endtask

  task automatic check_vec(input logic [3:0] got, input logic [3:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Bus cycles, strobe over one rising edge
  task automatic mem_write(input logic [DATA_SIZE-1:0] a, input logic [WIDTH-1:0] d);
    @(negedge clk);
    bus.addr   = 15'(a);
    bus.dout   = d;
    bus.mem_wr = 1'b1;
    @(negedge clk);
    bus.mem_wr = 1'b0;
  endtask

  task automatic mem_read(input logic [DATA_SIZE-1:0] a, output logic [WIDTH-1:0] d);
    @(negedge clk);
    bus.addr   = 15'(a);
    bus.mem_rd = 1'b1;
    @(negedge clk);
    bus.mem_rd = 1'b0;
    d = mem_dout;                                 // Registered one cycle after mem_rd
  endtask

  task automatic io_write(input io_reg_e r, input logic [WIDTH-1:0] d);
    @(negedge clk);
    bus.addr  = 15'(r);
    bus.dout  = d;
    bus.io_wr = 1'b1;
    @(negedge clk);
    bus.io_wr = 1'b0;
  endtask

  task automatic io_read(input io_reg_e r, output logic [WIDTH-1:0] d);
    @(negedge clk);
    bus.addr  = 15'(r);
    bus.io_rd = 1'b1;
    @(negedge clk);
    bus.io_rd = 1'b0;
    d = io_dout;
  endtask

  task automatic wait_full();
    logic [WIDTH-1:0] w;
    do io_read(IO_USTAT, w); while (!w[1]);
  endtask

  task automatic wait_ready();
    logic [WIDTH-1:0] w;
    do io_read(IO_USTAT, w); while (!w[0]);
  endtask

  task automatic ack_irq();
    @(negedge clk);
    iack = 1'b1;
    @(negedge clk);
    iack = 1'b0;
  endtask

  // Timeout
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    logic [WIDTH-1:0] w;
    logic [WIDTH-1:0] c1;
    logic [7:0]       b;
    errors = 0;
    checks = 0;
    cycles = 0;
    rng    = 32'hba82_f908;
    bus    = '0;
    iack   = 1'b0;
    pend_m = '0;
    @(posedge rst_n);

    // Status right after reset
    io_read(IO_USTAT, w);
    check_stat(uart_stat_t'(w[1:0]), exp_stat(1'b0, 1'b1), "reset status");
    check_vec({3'b0, irq}, 4'd0, "reset irq_o");

    // RAM random writes then readback
    for (int i = 0; i < RAM_N; i++) begin
      rng      = xorshift(rng);
      addrs[i] = rng[DATA_SIZE-1:0];
      rng      = xorshift(rng);
      shadow[addrs[i]] = rng[WIDTH-1:0];
      mem_write(addrs[i], rng[WIDTH-1:0]);
    end
    for (int i = 0; i < RAM_N; i++) begin
      mem_read(addrs[i], w);
      check_word(w, shadow[addrs[i]], "RAM read");
    end

    // UART loopback
    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      b   = rng[7:0];
      io_write(IO_UDATA, WIDTH'(b));
      wait_full();
      io_read(IO_UDATA, w);
      check_word(w, WIDTH'(b), "loopback byte");
      wait_ready();
      io_read(IO_USTAT, w);
      check_stat(uart_stat_t'(w[1:0]), exp_stat(1'b0, 1'b1), "status after read");
    end

    // Second write while busy is dropped
    io_write(IO_UDATA, WIDTH'(8'h5a));
    io_write(IO_UDATA, WIDTH'(8'ha5));             // Ready is low here
    wait_full();
    io_read(IO_UDATA, w);
    check_word(w, WIDTH'(8'h5a), "first byte of busy pair");
    wait_ready();
    repeat (120) @(negedge clk);                  // Longer than one frame
    io_read(IO_USTAT, w);
    check_stat(uart_stat_t'(w[1:0]), exp_stat(1'b0, 1'b1), "no second byte");

    // Interrupt priority and acknowledge
    while (irq) ack_irq();                        // Start from an empty set
    io_write(IO_UDATA, WIDTH'(8'h3c));
    wait_full();
    pend_m[IRQ_URX] = 1'b1;
    wait_ready();
    pend_m[IRQ_UTX] = 1'b1;
    io_read(IO_CYCLE, w);
    repeat (256 - int'(w[7:0]) + 2) @(negedge clk);  // Past exactly one wrap
    pend_m[IRQ_CYCLE] = 1'b1;
    for (int k = 0; k < 3; k++) begin
      check_vec(ivec, exp_vec(pend_m), "ivec_o");
      pend_m[exp_vec(pend_m)] = 1'b0;
      ack_irq();
    end
    check_vec(ivec, exp_vec(pend_m), "ivec_o after acks");
    check_vec({3'b0, irq}, 4'd0, "irq_o after acks");
    io_read(IO_UDATA, w);                         // Drain the held byte
    check_word(w, WIDTH'(8'h3c), "irq test byte");

    // Cycle counter, strobes GAP+2 cycles apart
    io_read(IO_CYCLE, c1);
    repeat (GAP) @(negedge clk);
    io_read(IO_CYCLE, w);
    check_word(w, WIDTH'(8'(c1[7:0] + 8'(GAP + 2))), "cycle counter");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/tb_clk.sv ====
// Testbench clock and reset
// 20 ns clock, reset held low for two cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clk (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o) rst_n_o = 1'b1;              // Release away from the active edge
  end

  always #10 clk_o = ~clk_o;                      // 20 ns period

endmodule

`default_nettype wire
